//--- src/ice51_pkg.sv
`default_nettype none

package ice51_pkg;

   //////////////////////////////
   // uart timing
   localparam int BAUD_DIV   = 104;                    // cycles per bit minus one
   localparam int BAUD_CW    = $clog2(BAUD_DIV + 1);
   localparam int FRAME_BITS = 10;                     // start + 8 data + stop

   //////////////////////////////
   // memory map
   localparam int CODE_AW    = 8;
   localparam int CODE_DEPTH = 256;                    // also the boot load length

   localparam logic [15:0] TX_DATA_ADDR = 16'h0201;    // movx write sends a byte
   localparam logic [15:0] TX_STAT_ADDR = 16'h0200;    // bit 0 is tx busy

   //////////////////////////////
   // opcodes, standard 8051 encodings
   localparam logic [7:0] OP_NOP    = 8'h00;
   localparam logic [7:0] OP_LJMP   = 8'h02;
   localparam logic [7:0] OP_INCA   = 8'h04;
   localparam logic [7:0] OP_INCR   = 8'h08;  // rN forms, low bits pick the register
   localparam logic [7:0] OP_RRC    = 8'h13;
   localparam logic [7:0] OP_DECA   = 8'h14;
   localparam logic [7:0] OP_DECR   = 8'h18;
   localparam logic [7:0] OP_RL     = 8'h23;
   localparam logic [7:0] OP_ADDAI  = 8'h24;
   localparam logic [7:0] OP_ADDAR  = 8'h28;
   localparam logic [7:0] OP_ADDCI  = 8'h34;
   localparam logic [7:0] OP_JC     = 8'h40;
   localparam logic [7:0] OP_ORLAI  = 8'h44;
   localparam logic [7:0] OP_JNC    = 8'h50;
   localparam logic [7:0] OP_ANLAI  = 8'h54;
   localparam logic [7:0] OP_XRLAI  = 8'h64;
   localparam logic [7:0] OP_JZ     = 8'h60;
   localparam logic [7:0] OP_JNZ    = 8'h70;
   localparam logic [7:0] OP_MOVAI  = 8'h74;
   localparam logic [7:0] OP_MOVRI  = 8'h78;
   localparam logic [7:0] OP_SJMP   = 8'h80;
   localparam logic [7:0] OP_MOVDP  = 8'h90;
   localparam logic [7:0] OP_SUBBAI = 8'h94;
   localparam logic [7:0] OP_SUBBAR = 8'h98;
   localparam logic [7:0] OP_CLRC   = 8'hC3;
   localparam logic [7:0] OP_SETBC  = 8'hD3;
   localparam logic [7:0] OP_DJNZR  = 8'hD8;
   localparam logic [7:0] OP_MOVXAD = 8'hE0;
   localparam logic [7:0] OP_CLRA   = 8'hE4;
   localparam logic [7:0] OP_MOVAR  = 8'hE8;
   localparam logic [7:0] OP_MOVXDA = 8'hF0;
   localparam logic [7:0] OP_CPLA   = 8'hF4;
   localparam logic [7:0] OP_MOVRA  = 8'hF8;

   //////////////////////////////
   // shared types
   typedef enum logic [2:0] {
      FETCH,
      DECODE0,
      DECODE1,
      DECODE2,
      EXECUTE
   } seq_state_e;

   typedef struct packed {
      logic [7:0] opcode;
      logic [7:0] operand1;   // immediate, rel offset or address high
      logic [7:0] operand2;   // address low
   } instr_t;

   typedef struct packed {
      logic acc_zero;
      logic carry;
      logic djnz_nonzero;     // selected rN minus one is not zero
   } core_flags_t;

   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } uart_byte_t;

   // x8..xF opcodes are rN forms, fold them onto their x8 base
   function automatic logic [7:0] op_class(input logic [7:0] op);
      return op[3] ? {op[7:3], 3'b000} : op;
   endfunction

endpackage

`default_nettype wire

//--- src/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_uart_rx,
   output ice51_pkg::uart_byte_t o_byte
);
   import ice51_pkg::*;

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

   rx_state_e          state;
   logic [1:0]         sync;
   logic               rx;
   logic [BAUD_CW-1:0] cnt;
   logic               full_tick;
   logic               half_tick;
   logic [7:0]         shift;

   assign rx        = sync[1];
   assign full_tick = (cnt == BAUD_CW'(BAUD_DIV));
   assign half_tick = (cnt == BAUD_CW'(BAUD_DIV / 2));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) sync <= 2'b11;             // line idles high
      else         sync <= {sync[0], i_uart_rx};
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= RX_IDLE;
         cnt   <= '0;
         shift <= '0;
      end else begin
         cnt <= cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx) begin
                  state <= RX_START;
                  shift <= 8'h80;             // marker, falls out after 8 shifts
               end
            end
            RX_START: if (half_tick) begin
               cnt   <= '0;                   // now aligned to bit centres
               state <= rx ? RX_IDLE : RX_DATA;
            end
            RX_DATA: if (full_tick) begin
               cnt   <= '0;
               shift <= {rx, shift[7:1]};     // lsb first
               if (shift[0]) state <= RX_STOP;
            end
            RX_STOP: if (full_tick) state <= RX_IDLE;
            default: state <= RX_IDLE;
         endcase
      end
   end

   assign o_byte = '{valid: (state == RX_STOP) && full_tick, data: shift};

endmodule

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  ice51_pkg::uart_byte_t i_byte,
   output logic                  o_uart_tx,
   output logic                  o_busy
);
   import ice51_pkg::*;

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_e;

   tx_state_e          state;
   logic [BAUD_CW-1:0] timer;
   logic [3:0]         bit_cnt;
   logic [7:0]         shift;
   logic               tick;
   logic               finish;

   assign tick   = (timer == BAUD_CW'(BAUD_DIV));
   assign finish = tick && (bit_cnt == 4'(FRAME_BITS - 1));   // end of stop bit

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         timer   <= '0;
         bit_cnt <= '0;
         shift   <= '1;
      end else begin
         timer <= (state == TX_IDLE || tick) ? '0 : timer + 1'b1;
         case (state)
            TX_IDLE: if (i_byte.valid) begin
               state   <= TX_START;
               shift   <= i_byte.data;
               bit_cnt <= '0;
            end
            TX_START: if (tick) begin
               state   <= TX_SEND;
               bit_cnt <= bit_cnt + 1'b1;
            end
            TX_SEND: begin
               if (finish) begin
                  state <= TX_IDLE;
               end else if (tick) begin
                  shift   <= {1'b1, shift[7:1]};   // ones backfill the stop level
                  bit_cnt <= bit_cnt + 1'b1;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   assign o_uart_tx = (state == TX_START) ? 1'b0 :
                      (state == TX_SEND)  ? shift[0] : 1'b1;
   assign o_busy    = (state != TX_IDLE);

   // the program has to poll the status before writing
   a_no_write_busy: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_byte.valid |-> !o_busy) else $error("tx write while busy");

   // frame closes on a high stop bit and the line stays high
   a_idle_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
      $fell(o_busy) |-> o_uart_tx && $past(o_uart_tx)) else $error("tx line low in idle");

endmodule

`default_nettype wire

//--- src/code_store.sv
`timescale 1ns/1ps
`default_nettype none

module code_store (
   input  logic                          i_clk,
   input  logic                          i_nrst,
   input  ice51_pkg::uart_byte_t         i_byte,
   input  logic [ice51_pkg::CODE_AW-1:0] i_addr,
   output logic [7:0]                    o_data,
   output logic                          o_load_done
);
   import ice51_pkg::*;

   logic [7:0]         mem [CODE_DEPTH];
   logic [CODE_AW-1:0] load_cnt;
   logic               load_wr;

   assign load_wr = i_byte.valid && !o_load_done;

   always_ff @(posedge i_clk) begin
      if (load_wr) mem[load_cnt] <= i_byte.data;
      o_data <= mem[i_addr];                  // one cycle read
   end

   //////////////////////////////
   // boot load counter
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         load_cnt    <= '0;
         o_load_done <= 1'b0;
      end else if (load_wr) begin
         load_cnt <= load_cnt + 1'b1;
         if (load_cnt == CODE_AW'(CODE_DEPTH - 1)) o_load_done <= 1'b1;   // sticky
      end
   end

   // sender must stop after exactly CODE_DEPTH bytes
   a_no_late_load: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_byte.valid |-> !o_load_done) else $error("boot byte after load done");

endmodule

`default_nettype wire

//--- src/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
   input  logic                          i_clk,
   input  logic                          i_nrst,
   input  logic                          i_load_done,
   input  logic [7:0]                    i_code,
   input  ice51_pkg::core_flags_t        i_flags,
   output logic [ice51_pkg::CODE_AW-1:0] o_addr,
   output ice51_pkg::instr_t             o_instr,
   output logic                          o_exec
);
   import ice51_pkg::*;

   seq_state_e         state;
   seq_state_e         state_next;
   logic [CODE_AW-1:0] pc;
   logic [7:0]         op_now;
   logic [1:0]         len_now;
   logic               taken;
   logic               is_ljmp;

   // bytes per instruction, unknown opcodes run as one byte no-ops
   function automatic logic [1:0] instr_len(input logic [7:0] op);
      case (op_class(op))
         OP_LJMP, OP_MOVDP:                       return 2'd3;
         OP_ADDAI, OP_ADDCI, OP_SUBBAI, OP_ANLAI,
         OP_ORLAI, OP_XRLAI, OP_MOVAI, OP_MOVRI,
         OP_SJMP, OP_JZ, OP_JNZ, OP_JC, OP_JNC,
         OP_DJNZR:                                return 2'd2;
         default:                                 return 2'd1;
      endcase
   endfunction

   // opcode shows on the code bus in DECODE0, latched after that
   assign op_now  = (state == DECODE0) ? i_code : o_instr.opcode;
   assign len_now = instr_len(op_now);

   //////////////////////////////
   // sequencer
   always_comb begin
      state_next = state;
      case (state)
         FETCH:   if (i_load_done) state_next = DECODE0;
         DECODE0: state_next = (len_now != 2'd1) ? DECODE1 : EXECUTE;
         DECODE1: state_next = (len_now == 2'd3) ? DECODE2 : EXECUTE;
         DECODE2: state_next = EXECUTE;
         default: state_next = FETCH;         // EXECUTE is a single cycle
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) state <= FETCH;
      else         state <= state_next;
   end

   //////////////////////////////
   // branch decision
   always_comb begin
      case (op_class(o_instr.opcode))
         OP_SJMP:  taken = 1'b1;
         OP_JZ:    taken = i_flags.acc_zero;
         OP_JNZ:   taken = !i_flags.acc_zero;
         OP_JC:    taken = i_flags.carry;
         OP_JNC:   taken = !i_flags.carry;
         OP_DJNZR: taken = i_flags.djnz_nonzero;
         default:  taken = 1'b0;
      endcase
   end

   assign is_ljmp = (o_instr.opcode == OP_LJMP);

   // pc walks the instruction bytes, so in EXECUTE it points past it
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         pc <= '0;
      end else begin
         case (state)
            FETCH:   if (i_load_done) pc <= pc + 1'b1;
            DECODE0: if (len_now != 2'd1) pc <= pc + 1'b1;
            DECODE1: if (len_now == 2'd3) pc <= pc + 1'b1;
            EXECUTE: begin
               if (is_ljmp)    pc <= o_instr.operand2;        // low byte only
               else if (taken) pc <= pc + o_instr.operand1;   // signed rel wraps
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_instr <= '0;
      end else begin
         case (state)
            DECODE0: o_instr.opcode   <= i_code;
            DECODE1: o_instr.operand1 <= i_code;
            DECODE2: o_instr.operand2 <= i_code;
            default: ;
         endcase
      end
   end

   assign o_addr = pc;
   assign o_exec = (state == EXECUTE);

   a_state_legal: assert property (@(posedge i_clk) disable iff (!i_nrst)
      state inside {FETCH, DECODE0, DECODE1, DECODE2, EXECUTE})
      else $error("illegal sequencer state %0h", state);

endmodule

`default_nettype wire

//--- src/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
   input  logic                   i_clk,
   input  logic                   i_nrst,
   input  ice51_pkg::instr_t      i_instr,
   input  logic                   i_exec,
   input  logic                   i_tx_busy,
   output ice51_pkg::core_flags_t o_flags,
   output ice51_pkg::uart_byte_t  o_tx
);
   import ice51_pkg::*;

   logic [7:0]  acc;
   logic [7:0]  acc_next;
   logic        carry;
   logic        carry_next;
   logic [7:0]  regs [8];
   logic        reg_we;
   logic [7:0]  reg_wdata;
   logic [15:0] dptr;
   logic        dptr_we;
   logic        tx_wr;
   logic [7:0]  op;
   logic [2:0]  rsel;
   logic [7:0]  imm;
   logic [7:0]  rval;
   logic [7:0]  alu_b;
   logic        cin;
   logic [8:0]  sum;
   logic [8:0]  diff;

   assign op    = op_class(i_instr.opcode);
   assign rsel  = i_instr.opcode[2:0];
   assign imm   = i_instr.operand1;
   assign rval  = regs[rsel];

   //////////////////////////////
   // adder and subtractor
   assign alu_b = i_instr.opcode[3] ? rval : imm;   // rN form or #imm
   assign cin   = (op == OP_ADDCI) && carry;
   assign sum   = {1'b0, acc} + {1'b0, alu_b} + {8'd0, cin};
   assign diff  = {1'b0, acc} - {1'b0, alu_b} - {8'd0, carry};   // bit 8 is borrow

   always_comb begin
      acc_next   = acc;
      carry_next = carry;
      reg_we     = 1'b0;
      reg_wdata  = rval;
      dptr_we    = 1'b0;
      tx_wr      = 1'b0;
      case (op)
         OP_NOP:   ;
         OP_MOVAI: acc_next = imm;
         OP_ADDAI, OP_ADDAR, OP_ADDCI: begin
            acc_next   = sum[7:0];
            carry_next = sum[8];
         end
         OP_SUBBAI, OP_SUBBAR: begin
            acc_next   = diff[7:0];
            carry_next = diff[8];
         end
         OP_ANLAI: acc_next = acc & imm;
         OP_ORLAI: acc_next = acc | imm;
         OP_XRLAI: acc_next = acc ^ imm;
         OP_INCA:  acc_next = acc + 8'd1;     // carry untouched
         OP_DECA:  acc_next = acc - 8'd1;
         OP_CLRA:  acc_next = '0;
         OP_CPLA:  acc_next = ~acc;
         OP_RL:    acc_next = {acc[6:0], acc[7]};
         OP_RRC: begin
            acc_next   = {carry, acc[7:1]};   // rotate through carry
            carry_next = acc[0];
         end
         OP_CLRC:  carry_next = 1'b0;
         OP_SETBC: carry_next = 1'b1;
         OP_MOVAR: acc_next = rval;
         OP_MOVRA: begin
            reg_we    = 1'b1;
            reg_wdata = acc;
         end
         OP_MOVRI: begin
            reg_we    = 1'b1;
            reg_wdata = imm;
         end
         OP_INCR: begin
            reg_we    = 1'b1;
            reg_wdata = rval + 8'd1;
         end
         OP_DECR, OP_DJNZR: begin
            reg_we    = 1'b1;
            reg_wdata = rval - 8'd1;
         end
         OP_MOVDP: dptr_we = 1'b1;
         OP_MOVXAD: if (dptr == TX_STAT_ADDR) acc_next = {7'd0, i_tx_busy};
         OP_MOVXDA: tx_wr = (dptr == TX_DATA_ADDR);
         default:  ;                          // anything else is a no-op
      endcase
   end

   //////////////////////////////
   // architectural state
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
      end else if (i_exec) begin
         acc   <= acc_next;
         carry <= carry_next;
         if (dptr_we) dptr <= {i_instr.operand1, i_instr.operand2};
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         for (int i = 0; i < 8; i++) regs[i] <= '0;
      end else if (i_exec && reg_we) begin
         regs[rsel] <= reg_wdata;
      end
   end

   assign o_flags = '{acc_zero:     (acc == 8'd0),
                      carry:        carry,
                      djnz_nonzero: ((rval - 8'd1) != 8'd0)};

   assign o_tx = '{valid: i_exec && tx_wr, data: acc};

endmodule

`default_nettype wire

//--- src/ice51_top.sv
`timescale 1ns/1ps
`default_nettype none

module ice51_top (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_uart_rx,
   output logic o_uart_tx
);

   ice51_pkg::uart_byte_t         rx_byte;
   ice51_pkg::uart_byte_t         tx_byte;
   ice51_pkg::instr_t             instr;
   ice51_pkg::core_flags_t        flags;
   logic [ice51_pkg::CODE_AW-1:0] code_addr;
   logic [7:0]                    code_data;
   logic                          load_done;
   logic                          exec;
   logic                          tx_busy;

   uart_rx u_uart_rx (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_uart_rx (i_uart_rx),
      .o_byte    (rx_byte)
   );

   code_store u_code_store (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_byte      (rx_byte),
      .i_addr      (code_addr),
      .o_data      (code_data),
      .o_load_done (load_done)
   );

   fetch_unit u_fetch_unit (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_load_done (load_done),
      .i_code      (code_data),
      .i_flags     (flags),
      .o_addr      (code_addr),
      .o_instr     (instr),
      .o_exec      (exec)
   );

   exec_unit u_exec_unit (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_instr   (instr),
      .i_exec    (exec),
      .i_tx_busy (tx_busy),
      .o_flags   (flags),
      .o_tx      (tx_byte)
   );

   uart_tx u_uart_tx (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_byte    (tx_byte),
      .o_uart_tx (o_uart_tx),
      .o_busy    (tx_busy)
   );

endmodule

`default_nettype wire

//--- verification/ice51_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ice51_tb;
   import ice51_pkg::*;

   localparam int BIT_CYC = BAUD_DIV + 1;
   localparam int MAX_EXP = 32;

   logic       i_clk;
   logic       i_nrst;
   logic       i_uart_rx;
   logic       o_uart_tx;

   logic [7:0] prog [CODE_DEPTH];
   int         pc;
   logic [7:0] exp_mem [MAX_EXP];
   int         exp_cnt;
   int         got_cnt;
   logic       built;
   logic       boot_active;

   // monitor results for one frame
   logic       mon_chk;
   logic       mon_start;
   logic       mon_stop;
   logic       mon_stable;
   logic [7:0] mon_byte;

   // reference model state
   logic [7:0] m_acc;
   logic       m_c;
   logic [7:0] m_r5;

   ice51_top i_ice51_top (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_uart_rx (i_uart_rx),
      .o_uart_tx (o_uart_tx)
   );

   always #4 i_clk = ~i_clk;

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   //////////////////////////////
   // program builder
   task automatic emit(input logic [7:0] b);
      if (pc >= CODE_DEPTH) begin
         fail_now("program does not fit in code memory");
      end else begin
         prog[pc] = b;
         pc++;
      end
   endtask

   task automatic emit2(input logic [7:0] b0, input logic [7:0] b1);
      emit(b0);
      emit(b1);
   endtask

   // acc waits in r7 while busy is polled
   task automatic send_acc(input logic expect_it);
      emit(OP_MOVRA | 8'd7);
      emit(OP_MOVDP);
      emit2(TX_STAT_ADDR[15:8], TX_STAT_ADDR[7:0]);
      emit(OP_MOVXAD);
      emit2(OP_JNZ, 8'hFD);                  // back to the movx
      emit(OP_MOVAR | 8'd7);
      emit(OP_MOVDP);
      emit2(TX_DATA_ADDR[15:8], TX_DATA_ADDR[7:0]);
      emit(OP_MOVXDA);
      if (expect_it) begin
         exp_mem[exp_cnt] = m_acc;
         exp_cnt++;
      end
   endtask

   // fall through path sets bitv in r5
   task automatic branch_case(input int setup, input logic [7:0] op, input logic [7:0] bitv);
      logic taken;
      case (setup)
         0: begin
            emit(OP_CLRA);
            m_acc = 8'd0;
         end
         1: begin
            emit2(OP_MOVAI, 8'd1);
            m_acc = 8'd1;
         end
         2: begin
            emit(OP_CLRC);
            m_c = 1'b0;
         end
         default: begin
            emit(OP_SETBC);
            m_c = 1'b1;
         end
      endcase
      case (op)
         OP_JZ:   taken = (m_acc == 8'd0);
         OP_JNZ:  taken = (m_acc != 8'd0);
         OP_JC:   taken = m_c;
         default: taken = !m_c;
      endcase
      emit2(op, 8'd4);
      emit(OP_MOVAR | 8'd5);
      emit2(OP_ORLAI, bitv);
      emit(OP_MOVRA | 8'd5);
      if (!taken) begin
         m_r5  = m_r5 | bitv;
         m_acc = m_r5;
      end
   endtask

   task automatic build_program();
      logic [7:0] a [10];
      logic [8:0] t;
      logic [7:0] r1;
      logic [7:0] r2;
      logic       c_new;
      int         n;
      int         lj;
      for (int i = 0; i < CODE_DEPTH; i++) prog[i] = OP_NOP;
      pc      = 0;
      exp_cnt = 0;
      m_acc   = 8'd0;
      m_c     = 1'b0;
      for (int i = 0; i < 10; i++) a[i] = 8'($urandom);
      n = 1 + int'($urandom % 15);

      emit2(OP_MOVAI, a[0]);                 // mov a,#imm
      m_acc = a[0];
      send_acc(1'b1);

      emit2(OP_ADDAI, a[1]);
      t = {1'b0, m_acc} + {1'b0, a[1]};
      m_acc = t[7:0];
      m_c   = t[8];
      send_acc(1'b1);

      emit2(OP_MOVAI, a[2]);                 // addc picks up the add carry
      emit2(OP_ADDCI, a[3]);
      t = {1'b0, a[2]} + {1'b0, a[3]} + {8'd0, m_c};
      m_acc = t[7:0];
      m_c   = t[8];
      send_acc(1'b1);

      emit(OP_CLRA);                         // carry into acc bit 0
      emit2(OP_ADDCI, 8'd0);
      m_acc = {7'd0, m_c};
      m_c   = 1'b0;
      send_acc(1'b1);

      emit(OP_SETBC);
      emit2(OP_MOVAI, a[4]);
      emit2(OP_SUBBAI, a[5]);
      t = {1'b0, a[4]} - {1'b0, a[5]} - 9'd1;
      m_acc = t[7:0];
      m_c   = t[8];                          // borrow
      send_acc(1'b1);

      emit2(OP_MOVAI, a[9]);
      emit2(OP_ANLAI, a[5]);
      emit2(OP_ORLAI, a[6]);
      emit2(OP_XRLAI, a[7]);
      m_acc = ((a[9] & a[5]) | a[6]) ^ a[7];
      send_acc(1'b1);

      emit(OP_INCA);
      emit(OP_DECA);
      emit(OP_DECA);
      emit(OP_CPLA);
      emit(OP_RL);
      emit(OP_RRC);
      m_acc = ~(m_acc - 8'd1);
      m_acc = {m_acc[6:0], m_acc[7]};
      c_new = m_acc[0];
      m_acc = {m_c, m_acc[7:1]};
      m_c   = c_new;
      send_acc(1'b1);

      //////////////////////////////
      // working registers
      emit2(OP_MOVRI | 8'd1, a[8]);
      emit(OP_INCR | 8'd1);
      emit(OP_INCR | 8'd1);
      emit(OP_DECR | 8'd1);
      emit(OP_MOVAR | 8'd1);
      emit(OP_MOVRA | 8'd2);
      emit(OP_INCR | 8'd2);
      emit(OP_MOVAR | 8'd2);
      emit(OP_ADDAR | 8'd1);
      emit(OP_CLRC);
      emit(OP_SUBBAR | 8'd1);
      r1 = a[8] + 8'd1;
      r2 = r1 + 8'd1;
      t  = {1'b0, r2} + {1'b0, r1};
      t  = {1'b0, t[7:0]} - {1'b0, r1};
      m_acc = t[7:0];
      m_c   = t[8];
      send_acc(1'b1);

      emit2(OP_MOVRI | 8'd3, 8'(n));         // djnz loop counts passes in acc
      emit(OP_CLRA);
      emit(OP_INCA);
      emit2(OP_DJNZR | 8'd3, 8'hFD);
      m_acc = 8'(n);
      send_acc(1'b1);

      //////////////////////////////
      // conditional branches
      emit2(OP_MOVRI | 8'd5, 8'd0);
      m_r5 = 8'd0;
      branch_case(0, OP_JZ,  8'h01);
      branch_case(1, OP_JZ,  8'h02);
      branch_case(1, OP_JNZ, 8'h04);
      branch_case(0, OP_JNZ, 8'h08);
      branch_case(3, OP_JC,  8'h10);
      branch_case(2, OP_JC,  8'h20);
      branch_case(2, OP_JNC, 8'h40);
      branch_case(3, OP_JNC, 8'h80);
      emit(OP_MOVAR | 8'd5);
      m_acc = m_r5;
      send_acc(1'b1);

      lj = pc + 3 + 14;                      // past the skipped block
      emit(OP_LJMP);
      emit2(8'd0, 8'(lj));
      emit2(OP_MOVAI, 8'hEE);                // never sent
      send_acc(1'b0);
      emit2(OP_SJMP, 8'hFE);                 // park here
   endtask

   //////////////////////////////
   // uart driver
   task automatic uart_send(input logic [7:0] b, input logic last);
      i_uart_rx = 1'b0;
      repeat (BIT_CYC) @(negedge i_clk);
      for (int i = 0; i < 8; i++) begin
         i_uart_rx = b[i];
         repeat (BIT_CYC) @(negedge i_clk);
      end
      i_uart_rx = 1'b1;
      repeat (BIT_CYC / 4) @(negedge i_clk);
      if (last) boot_active = 1'b0;          // before the core starts
      repeat (BIT_CYC - BIT_CYC / 4) @(negedge i_clk);
   endtask

   //////////////////////////////
   // tx monitor
   initial begin : tx_monitor
      logic [9:0] head;
      logic [9:0] mid;
      logic [9:0] tail;
      mon_chk    = 1'b0;
      mon_start  = 1'b0;
      mon_stop   = 1'b1;
      mon_stable = 1'b1;
      mon_byte   = 8'd0;
      got_cnt    = 0;
      forever begin
         @(negedge i_clk);
         if (mon_chk) begin
            mon_chk = 1'b0;
            got_cnt++;
         end
         if (i_nrst && o_uart_tx === 1'b0) begin
            for (int k = 0; k < 10; k++) begin
               head[k] = o_uart_tx;          // just past the bit edge
               repeat (BIT_CYC / 2) @(negedge i_clk);
               mid[k] = o_uart_tx;           // bit centre
               repeat (BIT_CYC - 1 - BIT_CYC / 2) @(negedge i_clk);
               tail[k] = o_uart_tx;          // just before the next edge
               if (k < 9) @(negedge i_clk);
            end
            mon_start  = mid[0];
            mon_stop   = mid[9];
            mon_stable = (head == mid) && (tail == mid);
            mon_byte   = mid[8:1];
            mon_chk    = 1'b1;
         end
      end
   end

   //////////////////////////////
   // checks
   a_boot_idle: assert property (@(posedge i_clk) disable iff (!i_nrst)
      boot_active |-> o_uart_tx)
      else fail_now($sformatf("ERROR: o_uart_tx got %0h expected 1 during boot load", o_uart_tx));

   a_start_low: assert property (@(posedge i_clk) mon_chk |-> !mon_start)
      else fail_now($sformatf("ERROR: o_uart_tx start bit got %0h expected 0", mon_start));

   a_stop_high: assert property (@(posedge i_clk) mon_chk |-> mon_stop)
      else fail_now($sformatf("ERROR: o_uart_tx stop bit got %0h expected 1", mon_stop));

   a_bit_width: assert property (@(posedge i_clk) mon_chk |-> mon_stable)
      else fail_now("tx bit period is not BAUD_DIV+1 cycles");

   a_no_extra: assert property (@(posedge i_clk) mon_chk |-> (got_cnt < exp_cnt))
      else fail_now($sformatf("more tx bytes than the %0d expected", exp_cnt));

   a_tx_data: assert property (@(posedge i_clk)
      (mon_chk && got_cnt < exp_cnt) |-> (mon_byte == exp_mem[got_cnt]))
      else fail_now($sformatf("ERROR: o_uart_tx byte %0d got %02h expected %02h",
                              got_cnt, mon_byte, exp_mem[got_cnt]));

   initial begin : watchdog
      wait (built);
      repeat ((CODE_DEPTH + exp_cnt + 4) * FRAME_BITS * BIT_CYC) @(posedge i_clk);
      fail_now($sformatf("timeout, only %0d of %0d bytes received", got_cnt, exp_cnt));
   end

   initial begin : main
      i_clk       = 1'b0;
      i_nrst      = 1'b0;
      i_uart_rx   = 1'b1;
      built       = 1'b0;
      boot_active = 1'b1;
      void'($urandom(11693));
      build_program();
      built = 1'b1;
      repeat (16) @(negedge i_clk);
      i_nrst = 1'b1;
      for (int i = 0; i < CODE_DEPTH; i++) uart_send(prog[i], i == CODE_DEPTH - 1);
      wait (got_cnt == exp_cnt);
      repeat (2 * FRAME_BITS * BIT_CYC) @(negedge i_clk);   // room for a stray frame
      if (got_cnt == exp_cnt) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         fail_now($sformatf("byte count %0d differs from %0d expected", got_cnt, exp_cnt));
      end
   end

endmodule

`default_nettype wire

//--- ice51_top.f
src/ice51_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/code_store.sv
src/fetch_unit.sv
src/exec_unit.sv
src/ice51_top.sv
verification/ice51_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ice51_tb
FILELIST  ?= ice51_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
